// File: design/addr_decode.sv
`timescale 1ns/100ps

// stage 1: region decode and kickstart overlay
module addr_decode import bus_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  req_t       in,
	input  logic       in_valid,
	output logic       in_ready,
	output dec_t       out,
	output logic       out_valid,
	input  logic       out_ready,
	input  logic [1:0] chip_size
);

	localparam int CIAA_LSB = 11;	// 4K byte page -> word bit 11
	localparam int RTC_LSB  = 15;	// 64K byte page -> word bit 15

	logic [ADDR_W-1:0] chip_limit;
	region_t           region;
	logic              ovl;	// kickstart overlay
	logic              ovl_hit;
	dec_t              dec;

	// chip ram is 512K * (chip_size + 1)
	assign chip_limit = CHIP_BASE + ADDR_W'(chip_size + 3'd1) * CHIP_512K;

	// --------------------------------------------------------------------------
	// region decode, chip first so it wins over everything
	// --------------------------------------------------------------------------
	always_comb begin
		if (in.addr < chip_limit)
			region = REG_CHIP;
		else if (in.addr >= KICK_BASE)
			region = REG_KICK;
		else if (in.addr[ADDR_W-1:CIAA_LSB] == CIAA_BASE[ADDR_W-1:CIAA_LSB])
			region = REG_CIAA;
		else if (in.addr[ADDR_W-1:RTC_LSB] == RTC_BASE[ADDR_W-1:RTC_LSB])
			region = REG_RTC;
		else
			region = REG_NONE;	// unmapped
	end

	// overlay maps reads of the first 512K onto the kick bank
	assign ovl_hit = ovl && !in.wr && region == REG_CHIP && in.addr < CHIP_512K;

	always_comb begin
		dec.req    = in;
		dec.region = region;
		dec.bank   = region == REG_KICK || ovl_hit;
	end

	// set by reset, any cia-a write clears it on the transfer edge
	always_ff @(posedge clk) begin
		if (!rst_n)
			ovl <= 1'b1;
		else if (in_valid && in_ready && in.wr && region == REG_CIAA)
			ovl <= 1'b0;
	end

	pipe_reg #(
		.payload_t(dec_t)
	) u_pipe (
		.clk      (clk),
		.rst_n    (rst_n),
		.in       (dec),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.out      (out),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	// stage 2 relies on the bank bit only for chip and kick
	a_bank_region: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !out.bank || out.region inside {REG_CHIP, REG_KICK});

endmodule

// File: design/bus_pkg.sv
package bus_pkg;

	// --------------------------------------------------------------------------
	// cpu bus widths
	// --------------------------------------------------------------------------
	localparam int ADDR_W = 23;	// word address, cpu a[23:1]
	localparam int DATA_W = 16;

	// region bases as word addresses (byte address >> 1)
	localparam logic [ADDR_W-1:0] CHIP_BASE = 23'h000000;
	localparam logic [ADDR_W-1:0] KICK_BASE = 23'h7c0000;	// $f80000 up to the top
	localparam logic [ADDR_W-1:0] CIAA_BASE = 23'h5ff000;	// $bfe page
	localparam logic [ADDR_W-1:0] RTC_BASE  = 23'h6e0000;	// $dc page
	localparam logic [ADDR_W-1:0] CHIP_512K = 23'h040000;	// 512K bytes in words

	// --------------------------------------------------------------------------
	// region and stage payloads
	// --------------------------------------------------------------------------
	typedef enum logic [2:0] {
		REG_CHIP,
		REG_KICK,
		REG_CIAA,
		REG_RTC,
		REG_NONE	// unmapped, answered with err
	} region_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              wr;	// 1 = write
		logic [1:0]        be;	// [1] upper byte, [0] lower byte
		logic [DATA_W-1:0] wdata;
	} req_t;

	typedef struct packed {
		req_t    req;
		region_t region;
		logic    bank;	// 1 = kick bank
	} dec_t;

	typedef struct packed {
		region_t           region;
		logic [1:0]        be;
		logic [DATA_W-1:0] rdata;	// raw word, zero for writes
	} acc_t;

	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic              err;
	} resp_t;

endpackage

// File: design/chip_bus_top.sv
`timescale 1ns/100ps

// cpu side of the chip bus, decode -> access -> response
module chip_bus_top import bus_pkg::*; #(
	parameter int MEM_AW = 6
) (
	input  logic        clk,
	input  logic        rst_n,
	input  req_t        req,
	input  logic        req_valid,
	output logic        req_ready,
	output resp_t       resp,
	output logic        resp_valid,
	input  logic        resp_ready,
	input  logic [1:0]  chip_size,	// chip ram = 512K * (chip_size + 1)
	input  logic        rom_readonly,
	input  logic [63:0] rtc
);

	// --------------------------------------------------------------------------
	// stage links
	// --------------------------------------------------------------------------
	dec_t dec;
	logic dec_valid;
	logic dec_ready;
	acc_t acc;
	logic acc_valid;
	logic acc_ready;

	addr_decode u_addr_decode (
		.clk      (clk),
		.rst_n    (rst_n),
		.in       (req),
		.in_valid (req_valid),
		.in_ready (req_ready),
		.out      (dec),
		.out_valid(dec_valid),
		.out_ready(dec_ready),
		.chip_size(chip_size)
	);

	mem_access #(
		.MEM_AW(MEM_AW)
	) u_mem_access (
		.clk         (clk),
		.rst_n       (rst_n),
		.in          (dec),
		.in_valid    (dec_valid),
		.in_ready    (dec_ready),
		.out         (acc),
		.out_valid   (acc_valid),
		.out_ready   (acc_ready),
		.rom_readonly(rom_readonly),
		.rtc         (rtc)
	);

	resp_stage u_resp_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.in       (acc),
		.in_valid (acc_valid),
		.in_ready (acc_ready),
		.out      (resp),
		.out_valid(resp_valid),
		.out_ready(resp_ready)
	);

endmodule

// File: design/mem_access.sv
`timescale 1ns/100ps

// stage 2: banked memory model and rtc nibble read
module mem_access import bus_pkg::*; #(
	parameter int MEM_AW = 6	// word address bits per bank
) (
	input  logic        clk,
	input  logic        rst_n,
	input  dec_t        in,
	input  logic        in_valid,
	output logic        in_ready,
	output acc_t        out,
	output logic        out_valid,
	input  logic        out_ready,
	input  logic        rom_readonly,
	input  logic [63:0] rtc
);

	localparam int DEPTH = 2 ** (MEM_AW + 1);	// chip bank + kick bank

	logic [DATA_W-1:0] mem [DEPTH];	// bank bit is the index msb
	logic [MEM_AW:0]   idx;
	logic              load;
	logic              mem_sel;
	logic              mem_we;
	logic [DATA_W-1:0] rd_word;
	logic [3:0]        rtc_nib;
	acc_t              acc;

	// larger regions alias in the low word bits
	assign idx     = {in.bank, in.req.addr[MEM_AW-1:0]};
	assign load    = in_valid && in_ready;	// stage 2 register loads now
	assign mem_sel = in.region inside {REG_CHIP, REG_KICK};
	assign mem_we  = load && in.req.wr && mem_sel && !(in.bank && rom_readonly);

	// --------------------------------------------------------------------------
	// memory, byte lane writes
	// --------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (mem_we) begin
			if (in.req.be[1])
				mem[idx][15:8] <= in.req.wdata[15:8];
			if (in.req.be[0])
				mem[idx][7:0] <= in.req.wdata[7:0];
		end
	end

	assign rd_word = mem[idx];	// async read, sees all earlier writes
	assign rtc_nib = rtc[{in.req.addr[4:1], 2'b00} +: 4];	// byte a[5:2]

	always_comb begin
		acc.region = in.region;
		acc.be     = in.req.be;
		acc.rdata  = '0;	// writes, cia-a and unmapped read zero
		if (!in.req.wr) begin
			case (in.region)
				REG_CHIP, REG_KICK: acc.rdata = rd_word;
				REG_RTC:            acc.rdata = {{(DATA_W-4){1'b0}}, rtc_nib};
				default:            acc.rdata = '0;
			endcase
		end
	end

	pipe_reg #(
		.payload_t(acc_t)
	) u_pipe (
		.clk      (clk),
		.rst_n    (rst_n),
		.in       (acc),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.out      (out),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	// a protected kick write leaves the addressed word untouched
	a_rom_protect: assert property (@(posedge clk) disable iff (!rst_n)
		load && in.req.wr && in.bank && rom_readonly
		|=> mem[$past(idx)] === $past(mem[idx]));

endmodule

// File: design/pipe_reg.sv
`timescale 1ns/100ps

// one-entry valid/ready stage register
module pipe_reg #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst_n,
	input  payload_t in,
	input  logic     in_valid,
	output logic     in_ready,
	output payload_t out,
	output logic     out_valid,
	input  logic     out_ready
);

	// free slot when empty or when the current item leaves this edge
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid;	// drops to 0 if nothing new arrives
	end

	// payload only, no reset
	always_ff @(posedge clk) begin
		if (in_valid && in_ready)
			out <= in;
	end

	// a stalled item must sit still until it is taken
	a_hold_stall: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out));

endmodule

// File: design/resp_stage.sv
`timescale 1ns/100ps

// stage 3: lane masking and error flag
module resp_stage import bus_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  acc_t  in,
	input  logic  in_valid,
	output logic  in_ready,
	output resp_t out,
	output logic  out_valid,
	input  logic  out_ready
);

	logic [DATA_W-1:0] lane_mask;
	logic              is_err;
	resp_t             resp;

	// one mask byte per enable
	assign lane_mask = {{(DATA_W/2){in.be[1]}}, {(DATA_W/2){in.be[0]}}};
	assign is_err    = in.region == REG_NONE;

	always_comb begin
		resp.err   = is_err;
		resp.rdata = is_err ? '0 : in.rdata & lane_mask;	// unmapped reads zero
	end

	pipe_reg #(
		.payload_t(resp_t)
	) u_pipe (
		.clk      (clk),
		.rst_n    (rst_n),
		.in       (resp),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.out      (out),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

// File: src.f
design/bus_pkg.sv
design/pipe_reg.sv
design/addr_decode.sv
design/mem_access.sv
design/resp_stage.sv
design/chip_bus_top.sv
verification/bus_checker.sv
verification/chip_bus_tb.sv

// File: verification/bus_checker.sv
`timescale 1ns/100ps

// in-order response scoreboard for chip_bus_top
module bus_checker import bus_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  req_valid,
	input  logic  req_ready,
	input  resp_t resp,
	input  logic  resp_valid,
	input  logic  resp_ready
);

	logic [DATA_W:0] exp_q [$];	// {rdata, err}, oldest first
	string           name_q [$];
	logic [DATA_W:0] exp_word;
	string           exp_name;
	logic            stalled;	// offered but not taken at the last edge
	logic            exp_ready;
	int              in_flight;	// accepted, not yet answered
	resp_t           held;
	int              n_mismatch   = 0;
	int              n_unexpected = 0;
	int              n_protocol   = 0;
	int              n_checked    = 0;

	task automatic push(input logic [DATA_W-1:0] rdata, input logic err, input string name);
		exp_q.push_back({rdata, err});
		name_q.push_back(name);
	endtask

	function automatic int pending();
		return exp_q.size();
	endfunction

	// responses still owed count as errors too
	function automatic int error_count();
		return n_mismatch + n_unexpected + n_protocol + exp_q.size();
	endfunction

	task automatic report(input int run_errors);
		$display("errors: %0d mismatch, %0d unexpected, %0d protocol, %0d missing, %0d run%s",
			n_mismatch, n_unexpected, n_protocol, exp_q.size(), run_errors,
			$sformatf(" (%0d checked)", n_checked));
	endtask

	// --------------------------------------------------------------------------
	// request side, ready only falls with all three stages full
	// --------------------------------------------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			in_flight = 0;
		end else begin
			exp_ready = in_flight < 3 || resp_ready;	// a full pipe moves when resp is taken
			if (req_ready !== exp_ready) begin
				$display("FAILED req_ready at %0t: expected %b, actual %b", $time,
					exp_ready, req_ready);
				n_mismatch++;
			end
			if (req_valid && req_ready)
				in_flight++;
			if (resp_valid && resp_ready)
				in_flight--;
		end
	end

	// --------------------------------------------------------------------------
	// response side monitor
	// --------------------------------------------------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			stalled = 1'b0;
		end else begin
			if (stalled && !resp_valid) begin	// item withdrawn under back-pressure
				$display("resp_valid dropped at %0t before the response was taken", $time);
				n_protocol++;
			end else if (stalled && resp !== held) begin
				$display("response payload changed at %0t while it was stalled", $time);
				n_protocol++;
			end
			if (resp_valid && resp_ready) begin
				if (exp_q.size() == 0) begin
					$display("response %h err %b at %0t arrived with no request outstanding",
						resp.rdata, resp.err, $time);
					n_unexpected++;
				end else begin
					exp_word = exp_q.pop_front();
					exp_name = name_q.pop_front();
					n_checked++;
					if (resp.rdata !== exp_word[DATA_W:1] || resp.err !== exp_word[0]) begin
						$display("FAILED %s: expected %h err %b, actual %h err %b", exp_name,
							exp_word[DATA_W:1], exp_word[0], resp.rdata, resp.err);
						n_mismatch++;
					end
				end
			end
			stalled = resp_valid && !resp_ready;
			held    = resp;
		end
	end

endmodule

// File: verification/bus_stim.txt
# op byte_addr be wdata chip_size rom_readonly exp_rdata exp_err
# values in hex, one access per line, responses expected in this order
W 000010 3 1234 1 0 0000 0
W F80010 3 abcd 1 0 0000 0
R 000010 3 0000 1 0 abcd 0
R F80010 3 0000 1 0 abcd 0
R 080010 3 0000 1 0 1234 0
W BFE001 1 00ff 1 0 0000 0
R 000010 3 0000 1 0 1234 0
R BFE001 1 0000 1 0 0000 0
W 000010 2 ee55 1 0 0000 0
R 000010 3 0000 1 0 ee34 0
R 000010 1 0000 1 0 0034 0
R 000010 2 0000 1 0 ee00 0
W 000012 1 7788 1 0 0000 0
R 000012 1 0000 1 0 0088 0
R DC0014 3 0000 1 0 0008 0
R DC0038 3 0000 1 0 000c 0
R DC0038 2 0000 1 0 0000 0
R A00000 3 0000 1 0 0000 1
W A00000 3 1111 1 0 0000 1
W F80010 3 5555 1 1 0000 0
R F80010 3 0000 1 1 abcd 0
W 000014 3 4321 1 1 0000 0
R 000014 3 0000 1 1 4321 0
R 080000 3 0000 0 1 0000 1
W 080000 3 6789 1 1 0000 0
R 080000 3 0000 1 1 6789 0
W 080000 3 1111 0 1 0000 1
R 080000 1 0000 1 1 0089 0
W F80010 3 2468 1 0 0000 0
R F80010 3 0000 1 0 2468 0
R 000010 3 0000 1 0 ee34 0

// File: verification/chip_bus_tb.sv
`timescale 1ns/100ps

// testbench for chip_bus_top, one stim line per bus access
module chip_bus_tb import bus_pkg::*; ();

	typedef struct packed {
		logic        wr;
		logic [23:0] addr;	// byte address
		logic [1:0]  be;
		logic [15:0] wdata;
		logic [1:0]  chip_size;
		logic        rom_readonly;
		logic [15:0] exp_rdata;
		logic        exp_err;
	} stim_t;

	localparam int          MAX_STIM    = 64;
	localparam logic [63:0] RTC_PATTERN = 64'h3c5a_96e1_0f87_d24b;

	logic        clk;
	logic        rst_n;
	req_t        req;
	logic        req_valid;
	logic        req_ready;
	resp_t       resp;
	logic        resp_valid;
	logic        resp_ready;
	logic [1:0]  chip_size;
	logic        rom_readonly;
	logic [63:0] rtc;
	stim_t       stim_mem [MAX_STIM];
	stim_t       s;
	int          n_stim     = 0;
	int          limit      = 0;
	int          cycle_cnt  = 0;
	int          run_errors = 0;
	bit          loaded     = 1'b0;
	integer      seed       = 51;

	chip_bus_top u_chip_bus_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.resp        (resp),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.chip_size   (chip_size),
		.rom_readonly(rom_readonly),
		.rtc         (rtc)
	);

	bus_checker u_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.resp      (resp),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// random back-pressure, ready about 3 edges in 4
	always @(posedge clk)
		resp_ready <= ($random(seed) & 3) != 0;

	task automatic load_stim(output int count);
		int          fd;
		int          n;
		logic [7:0]  op;
		logic [23:0] addr;
		logic [1:0]  be;
		logic [1:0]  cs;
		logic [15:0] wdata;
		logic [15:0] erd;
		logic        ro;
		logic        eerr;
		reg [8*128-1:0] rest;
		count = 0;
		fd = $fopen("verification/bus_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open verification/bus_stim.txt");
		end else begin
			while (!$feof(fd) && count < MAX_STIM) begin
				n = $fscanf(fd, " %c %h %h %h %h %h %h %h",
					op, addr, be, wdata, cs, ro, erd, eerr);
				if (n == 8 && (op == "R" || op == "W")) begin
					stim_mem[count] = {op == "W", addr, be, wdata, cs, ro, erd, eerr};
					count++;
				end else if (n >= 0) begin
					n = $fgets(rest, fd);	// comment line, skip the rest
				end
			end
			$fclose(fd);
		end
	endtask

	// wait until every accepted request has been answered
	task automatic drain_pipeline();
		req_valid <= 1'b0;
		while (u_checker.pending() != 0)
			@(posedge clk);
	endtask

	task automatic finish_run();
		u_checker.report(run_errors);
		if (run_errors == 0 && u_checker.error_count() == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	// --------------------------------------------------------------------------
	// watchdog, 20 cycles per access plus margin
	// --------------------------------------------------------------------------
	initial begin
		wait (loaded);
		while (cycle_cnt < limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, responses still outstanding", cycle_cnt);
		run_errors++;
		finish_run();
	end

	initial begin
		rst_n        = 1'b0;
		req          = '0;
		req_valid    = 1'b0;
		resp_ready   = 1'b0;
		chip_size    = 2'd1;
		rom_readonly = 1'b0;
		rtc          = RTC_PATTERN;
		load_stim(n_stim);
		limit  = 20 * n_stim + 100;
		loaded = 1'b1;
		if (n_stim == 0) begin
			$display("no stimulus lines were read");
			run_errors++;
			finish_run();
		end else begin
			repeat (5) @(posedge clk);
			rst_n <= 1'b1;
			for (int i = 0; i < n_stim; i++) begin
				s = stim_mem[i];
				if (s.rom_readonly != rom_readonly) begin	// stage 2 sees it, so empty first
					drain_pipeline();
					rom_readonly <= s.rom_readonly;
				end
				req       <= {s.addr[23:1], s.wr, s.be, s.wdata};
				chip_size <= s.chip_size;
				req_valid <= 1'b1;
				@(posedge clk);
				while (!req_ready)
					@(posedge clk);
				u_checker.push(s.exp_rdata, s.exp_err,
					$sformatf("stim%0d %s %06h", i + 1, s.wr ? "W" : "R", s.addr));
			end
			drain_pipeline();
			repeat (10) @(posedge clk);	// catch any stray response
			finish_run();
		end
	end

endmodule
